// ==== hdl/cpu_pkg.sv ====
package cpu_pkg;

    // Widths fixed by the instruction encoding
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 12;
    localparam int REG_COUNT = 16;
    localparam int FLAG_W    = 5;

    typedef enum logic [3:0] {
        NOP = 4'd0,
        LD  = 4'd1,
        STR = 4'd2,
        BRA = 4'd3,
        XOR = 4'd4,
        ADD = 4'd5,
        ROT = 4'd6,
        SHF = 4'd7,
        HLT = 4'd8,
        CMP = 4'd9
    } opcode_t;

    // Branch conditions, tested against the status register
    typedef enum logic [2:0] {
        COND_ALWAYS   = 3'd0,
        COND_PARITY   = 3'd1,
        COND_EVEN     = 3'd2,
        COND_CARRY    = 3'd3,
        COND_NEG      = 3'd4,
        COND_ZERO     = 3'd5,
        COND_NO_CARRY = 3'd6,
        COND_NOT_ZERO = 3'd7
    } cond_t;

    typedef enum logic [2:0] {
        FETCH      = 3'd0,
        DECODE     = 3'd1,
        EXECUTE    = 3'd2,
        MEM_ACCESS = 3'd3,
        WRITEBACK  = 3'd4,
        HALTED     = 3'd5
    } state_t;

    // Instruction fields
    localparam int OPC_HI        = 31;
    localparam int OPC_LO        = 28;
    localparam int COND_HI       = 27;
    localparam int COND_LO       = 25;
    localparam int IMM_FLAG_BIT  = 24;
    localparam int DST_HI        = 23;
    localparam int DST_LO        = 20;
    localparam int SRC_HI        = 19;
    localparam int SRC_LO        = 16;
    localparam int ADR_HI        = 11;
    localparam int ADR_LO        = 0;

    // Shift control inside the source operand
    localparam int SHIFT_DIR_BIT = 5;
    localparam int SHIFT_AMT_HI  = 4;
    localparam int SHIFT_AMT_LO  = 0;

    // Status register bits
    localparam int FLAG_Z        = 4;
    localparam int FLAG_N        = 3;
    localparam int FLAG_E        = 2;
    localparam int FLAG_P        = 1;
    localparam int FLAG_C        = 0;

endpackage

// ==== hdl/exec_if.sv ====
`timescale 1ns/1ps

interface exec_if;

    cpu_pkg::state_t              state;
    cpu_pkg::opcode_t             opcode;
    cpu_pkg::cond_t               cond;
    logic [cpu_pkg::DATA_W-1:0]   dst;
    logic [cpu_pkg::DATA_W-1:0]   src;

    // Unit results
    logic [cpu_pkg::DATA_W-1:0]   alu_result;
    logic                         alu_carry;
    logic [cpu_pkg::DATA_W-1:0]   shift_result;
    logic                         shift_carry;

    logic                         branch_taken;

    modport control (output state, opcode, cond, dst, src, input branch_taken);

    modport alu (input opcode, dst, src, output alu_result, alu_carry);

    modport shifter (input opcode, dst, src, output shift_result, shift_carry);

    modport merge (
        input  state, opcode, cond, dst, src,
        input  alu_result, alu_carry, shift_result, shift_carry,
        output branch_taken
    );

endinterface

// ==== hdl/cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control (
    input  logic                          clk,
    input  logic                          reset,

    // Shared memory port
    output logic                          mem_valid,
    output logic                          mem_write,
    output logic [cpu_pkg::ADDR_W-1:0]    mem_address,
    output logic [cpu_pkg::DATA_W-1:0]    mem_wdata,
    input  logic                          mem_ready,
    input  logic [cpu_pkg::DATA_W-1:0]    mem_rdata,
    output logic                          halted,

    // Register file
    output logic [3:0]                    rd_addr_a,
    output logic [3:0]                    rd_addr_b,
    input  logic [cpu_pkg::DATA_W-1:0]    rd_data_a,
    input  logic [cpu_pkg::DATA_W-1:0]    rd_data_b,
    output logic                          wr_en,
    output logic [3:0]                    wr_addr,
    output logic [cpu_pkg::DATA_W-1:0]    wr_data,

    input  logic [cpu_pkg::DATA_W-1:0]    merged_result,
    exec_if.control                       ex
);

    cpu_pkg::state_t              state;
    cpu_pkg::opcode_t             op;
    logic [cpu_pkg::ADDR_W-1:0]   pc;
    logic [cpu_pkg::DATA_W-1:0]   ir;
    logic [cpu_pkg::DATA_W-1:0]   dst_op;
    logic [cpu_pkg::DATA_W-1:0]   src_op;
    logic [cpu_pkg::ADDR_W-1:0]   ir_addr;
    logic                         fetch_issue;
    logic                         fetch_done;
    logic                         data_issue;
    logic                         data_done;

    assign op      = cpu_pkg::opcode_t'(ir[cpu_pkg::OPC_HI:cpu_pkg::OPC_LO]);
    assign ir_addr = ir[cpu_pkg::ADR_HI:cpu_pkg::ADR_LO];

    // Request is raised one cycle into FETCH or MEM_ACCESS
    assign fetch_issue = (state == cpu_pkg::FETCH) && !mem_valid;
    assign fetch_done  = (state == cpu_pkg::FETCH) && mem_valid && mem_ready;
    assign data_issue  = (state == cpu_pkg::MEM_ACCESS) && !mem_valid;
    assign data_done   = (state == cpu_pkg::MEM_ACCESS) && mem_valid && mem_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= cpu_pkg::FETCH;
            pc        <= '0;
            mem_valid <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            case (state)
                cpu_pkg::FETCH: begin
                    if (fetch_issue) begin
                        mem_valid <= 1'b1;
                        mem_write <= 1'b0;
                    end else if (fetch_done) begin
                        mem_valid <= 1'b0;
                        state     <= cpu_pkg::DECODE;
                    end
                end
                cpu_pkg::DECODE: state <= cpu_pkg::EXECUTE;
                cpu_pkg::EXECUTE: begin
                    if (op == cpu_pkg::LD || op == cpu_pkg::STR) begin
                        state <= cpu_pkg::MEM_ACCESS;
                    end else begin
                        state <= cpu_pkg::WRITEBACK;
                    end
                end
                cpu_pkg::MEM_ACCESS: begin
                    if (data_issue) begin
                        mem_valid <= 1'b1;
                        mem_write <= (op == cpu_pkg::STR);
                    end else if (data_done) begin
                        mem_valid <= 1'b0;
                        mem_write <= 1'b0;
                        state     <= cpu_pkg::WRITEBACK;
                    end
                end
                cpu_pkg::WRITEBACK: begin
                    if (op == cpu_pkg::BRA && ex.branch_taken) begin
                        pc <= ir_addr;
                    end else begin
                        pc <= pc + 1'b1;
                    end
                    state <= (op == cpu_pkg::HLT) ? cpu_pkg::HALTED : cpu_pkg::FETCH;
                end
                default: state <= cpu_pkg::HALTED;
            endcase
        end
    end

    // Instruction, operands and request payload
    always_ff @(posedge clk) begin
        if (fetch_issue) begin
            mem_address <= pc;
        end
        if (fetch_done) begin
            ir <= mem_rdata;
        end
        if (state == cpu_pkg::DECODE) begin
            dst_op <= rd_data_a;
            if (ir[cpu_pkg::IMM_FLAG_BIT]) begin
                src_op <= {{(cpu_pkg::DATA_W - cpu_pkg::ADDR_W){1'b0}}, ir_addr};
            end else begin
                src_op <= rd_data_b;
            end
        end
        if (data_issue) begin
            mem_address <= ir_addr;
            mem_wdata   <= dst_op;
        end
        // Loaded word rides on the destination operand into WRITEBACK
        if (data_done && op == cpu_pkg::LD) begin
            dst_op <= mem_rdata;
        end
    end

    assign rd_addr_a = ir[cpu_pkg::DST_HI:cpu_pkg::DST_LO];
    assign rd_addr_b = ir[cpu_pkg::SRC_HI:cpu_pkg::SRC_LO];

    always_comb begin
        case (op)
            cpu_pkg::LD, cpu_pkg::XOR, cpu_pkg::ADD,
            cpu_pkg::ROT, cpu_pkg::SHF, cpu_pkg::CMP: wr_en = (state == cpu_pkg::WRITEBACK);
            default:                                  wr_en = 1'b0;
        endcase
    end

    assign wr_addr = ir[cpu_pkg::DST_HI:cpu_pkg::DST_LO];
    assign wr_data = (op == cpu_pkg::LD) ? dst_op : merged_result;

    assign ex.state  = state;
    assign ex.opcode = op;
    assign ex.cond   = cpu_pkg::cond_t'(ir[cpu_pkg::COND_HI:cpu_pkg::COND_LO]);
    assign ex.dst    = dst_op;
    assign ex.src    = src_op;

    assign halted = (state == cpu_pkg::HALTED);

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [3:0]                    rd_addr_a,
    input  logic [3:0]                    rd_addr_b,
    input  logic                          wr_en,
    input  logic [3:0]                    wr_addr,
    input  logic [cpu_pkg::DATA_W-1:0]    wr_data,
    output logic [cpu_pkg::DATA_W-1:0]    rd_data_a,
    output logic [cpu_pkg::DATA_W-1:0]    rd_data_b
);

    logic [cpu_pkg::DATA_W-1:0] regs [cpu_pkg::REG_COUNT];

    // Single write port
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < cpu_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads are combinational
    assign rd_data_a = regs[rd_addr_a];
    assign rd_data_b = regs[rd_addr_b];

endmodule

// ==== hdl/arith_logic_unit.sv ====
`timescale 1ns/1ps

module arith_logic_unit (
    exec_if.alu ex
);

    logic [cpu_pkg::DATA_W:0] sum;

    // Extra bit keeps the carry out
    assign sum = {1'b0, ex.dst} + {1'b0, ex.src};

    always_comb begin
        case (ex.opcode)
            cpu_pkg::ADD: ex.alu_result = sum[cpu_pkg::DATA_W-1:0];
            cpu_pkg::XOR: ex.alu_result = ex.dst ^ ex.src;
            // Complement of the source
            cpu_pkg::CMP: ex.alu_result = ~ex.src;
            default:      ex.alu_result = ex.dst;
        endcase
    end

    assign ex.alu_carry = sum[cpu_pkg::DATA_W];

endmodule

// ==== hdl/shift_rotate_unit.sv ====
`timescale 1ns/1ps

module shift_rotate_unit (
    exec_if.shifter ex
);

    localparam int W = cpu_pkg::DATA_W;

    logic [4:0]       amount;
    logic             right;
    logic [2*W-1:0]   shift_wide;
    logic [2*W-1:0]   rot_wide;
    logic [W-1:0]     shift_res;
    logic [W-1:0]     rot_res;
    logic             out_bit;

    assign amount = ex.src[cpu_pkg::SHIFT_AMT_HI:cpu_pkg::SHIFT_AMT_LO];
    assign right  = ex.src[cpu_pkg::SHIFT_DIR_BIT];

    // Padding beside the operand catches the bits that fall out
    always_comb begin
        if (right) begin
            shift_wide = {ex.dst, {W{1'b0}}} >> amount;
            rot_wide   = {ex.dst, ex.dst} >> amount;
            shift_res  = shift_wide[2*W-1:W];
            rot_res    = rot_wide[W-1:0];
            out_bit    = shift_wide[W-1];
        end else begin
            shift_wide = {{W{1'b0}}, ex.dst} << amount;
            rot_wide   = {ex.dst, ex.dst} << amount;
            shift_res  = shift_wide[W-1:0];
            rot_res    = rot_wide[2*W-1:W];
            out_bit    = shift_wide[W];
        end
    end

    assign ex.shift_result = (ex.opcode == cpu_pkg::ROT) ? rot_res : shift_res;

    // Zero amount leaves the padding untouched, so no carry
    assign ex.shift_carry = out_bit;

endmodule

// ==== hdl/result_merge.sv ====
`timescale 1ns/1ps

module result_merge (
    input  logic                          clk,
    input  logic                          reset,
    output logic [cpu_pkg::DATA_W-1:0]    merged_result,
    exec_if.merge                         ex
);

    logic [cpu_pkg::FLAG_W-1:0]   flags;
    logic [cpu_pkg::FLAG_W-1:0]   new_flags;
    logic [cpu_pkg::DATA_W-1:0]   sel_result;
    logic                         sel_carry;
    logic                         cond_met;
    logic                         set_flags;

    always_comb begin
        // LD falls through to the destination operand
        sel_result = ex.dst;
        sel_carry  = 1'b0;
        case (ex.opcode)
            cpu_pkg::ADD: begin
                sel_result = ex.alu_result;
                sel_carry  = ex.alu_carry;
            end
            cpu_pkg::XOR, cpu_pkg::CMP: sel_result = ex.alu_result;
            cpu_pkg::ROT, cpu_pkg::SHF: begin
                sel_result = ex.shift_result;
                sel_carry  = ex.shift_carry;
            end
            default: ;
        endcase

        new_flags = '0;
        new_flags[cpu_pkg::FLAG_Z] = ~|sel_result;
        new_flags[cpu_pkg::FLAG_N] = sel_result[cpu_pkg::DATA_W-1];
        new_flags[cpu_pkg::FLAG_E] = ~sel_result[0];
        new_flags[cpu_pkg::FLAG_P] = ^sel_result;
        new_flags[cpu_pkg::FLAG_C] = sel_carry;

        case (ex.opcode)
            cpu_pkg::XOR, cpu_pkg::ADD, cpu_pkg::ROT,
            cpu_pkg::SHF, cpu_pkg::CMP: set_flags = (ex.state == cpu_pkg::EXECUTE);
            // Load flags wait for the word in WRITEBACK
            cpu_pkg::LD:                set_flags = (ex.state == cpu_pkg::WRITEBACK);
            default:                    set_flags = 1'b0;
        endcase

        case (ex.cond)
            cpu_pkg::COND_ALWAYS:   cond_met = 1'b1;
            cpu_pkg::COND_PARITY:   cond_met = flags[cpu_pkg::FLAG_P];
            cpu_pkg::COND_EVEN:     cond_met = flags[cpu_pkg::FLAG_E];
            cpu_pkg::COND_CARRY:    cond_met = flags[cpu_pkg::FLAG_C];
            cpu_pkg::COND_NEG:      cond_met = flags[cpu_pkg::FLAG_N];
            cpu_pkg::COND_ZERO:     cond_met = flags[cpu_pkg::FLAG_Z];
            cpu_pkg::COND_NO_CARRY: cond_met = ~flags[cpu_pkg::FLAG_C];
            default:                cond_met = ~flags[cpu_pkg::FLAG_Z];
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            flags           <= '0;
            ex.branch_taken <= 1'b0;
        end else begin
            if (set_flags) begin
                flags <= new_flags;
            end else if (ex.state == cpu_pkg::EXECUTE && ex.opcode == cpu_pkg::STR) begin
                flags <= '0;
            end
            if (ex.state == cpu_pkg::EXECUTE) begin
                ex.branch_taken <= (ex.opcode == cpu_pkg::BRA) && cond_met;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex.state == cpu_pkg::EXECUTE) begin
            merged_result <= sel_result;
        end
    end

endmodule

// ==== hdl/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top (
    input  logic                          clk,
    input  logic                          reset,
    output logic                          mem_valid,
    output logic                          mem_write,
    output logic [cpu_pkg::ADDR_W-1:0]    mem_address,
    output logic [cpu_pkg::DATA_W-1:0]    mem_wdata,
    input  logic                          mem_ready,
    input  logic [cpu_pkg::DATA_W-1:0]    mem_rdata,
    output logic                          halted
);

    exec_if ex ();

    logic [3:0]                   rd_addr_a;
    logic [3:0]                   rd_addr_b;
    logic [cpu_pkg::DATA_W-1:0]   rd_data_a;
    logic [cpu_pkg::DATA_W-1:0]   rd_data_b;
    logic                         wr_en;
    logic [3:0]                   wr_addr;
    logic [cpu_pkg::DATA_W-1:0]   wr_data;
    logic [cpu_pkg::DATA_W-1:0]   merged_result;

    cpu_control u_control (
        .clk           (clk),
        .reset         (reset),
        .mem_valid     (mem_valid),
        .mem_write     (mem_write),
        .mem_address   (mem_address),
        .mem_wdata     (mem_wdata),
        .mem_ready     (mem_ready),
        .mem_rdata     (mem_rdata),
        .halted        (halted),
        .rd_addr_a     (rd_addr_a),
        .rd_addr_b     (rd_addr_b),
        .rd_data_a     (rd_data_a),
        .rd_data_b     (rd_data_b),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .merged_result (merged_result),
        .ex            (ex.control)
    );

    register_file u_regs (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b)
    );

    // Both units see the same operands
    arith_logic_unit u_alu (.ex(ex.alu));

    shift_rotate_unit u_shifter (.ex(ex.shifter));

    result_merge u_merge (
        .clk           (clk),
        .reset         (reset),
        .merged_result (merged_result),
        .ex            (ex.merge)
    );

endmodule

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clk,
    output logic reset
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held over the first three rising edges
    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        #10;
        reset = 1'b0;
    end

endmodule

// ==== testbench/cpu_assert.sv ====
`timescale 1ns/1ps

module cpu_assert (
    input logic        clk,
    input logic        reset,
    input logic        mem_valid,
    input logic        mem_write,
    input logic [11:0] mem_address,
    input logic [31:0] mem_wdata,
    input logic        mem_ready,
    input logic        halted
);

    int failures;

    initial begin
        failures = 0;
    end

    // Core comes out of reset idle
    idle_after_reset: assert property (
        @(posedge clk) reset |=> (!mem_valid && !mem_write && !halted)
    ) else begin
        failures++;
        $error("memory request or halted active right after reset");
    end

    // Back-pressure keeps the request frozen
    request_held: assert property (
        @(posedge clk) disable iff (reset)
        (mem_valid && !mem_ready) |=> (mem_valid && $stable(mem_address)
            && $stable(mem_write) && (!mem_write || $stable(mem_wdata)))
    ) else begin
        failures++;
        $error("memory request changed while waiting for ready");
    end

    no_request_halted: assert property (
        @(posedge clk) disable iff (reset) halted |-> !mem_valid
    ) else begin
        failures++;
        $error("memory request issued while halted");
    end

endmodule

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb;

    localparam int PROG_LEN    = 120;
    localparam int DATA_BASE   = 'h800;
    localparam int DATA_WORDS  = 64;
    localparam int RESULT_BASE = 'hC00;
    localparam int WAIT_LIMIT  = 60;

    logic        clk;
    logic        reset;
    logic        mem_valid;
    logic        mem_write;
    logic [11:0] mem_address;
    logic [31:0] mem_wdata;
    logic        mem_ready;
    logic [31:0] mem_rdata;
    logic        halted;

    // Memory seen by the DUT, and the copy the model works on
    logic [31:0] mem     [4096];
    logic [31:0] ref_mem [4096];
    logic [31:0] regs_m  [16];
    logic [4:0]  flags_m;
    logic [11:0] pc_m;
    int          error_count;
    int          instr_count;
    bit          timed_out;

    clock_gen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    cpu_top uut (
        .clk         (clk),
        .reset       (reset),
        .mem_valid   (mem_valid),
        .mem_write   (mem_write),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .halted      (halted)
    );

    bind cpu_top cpu_assert u_assert (
        .clk         (clk),
        .reset       (reset),
        .mem_valid   (mem_valid),
        .mem_write   (mem_write),
        .mem_address (mem_address),
        .mem_wdata   (mem_wdata),
        .mem_ready   (mem_ready),
        .halted      (halted)
    );

    // Random ready, with read data that follows the address
    task automatic serve_memory;
        forever begin
            @(posedge clk);
            #10;
            mem_ready = ($urandom % 4) != 0;
            mem_rdata = mem[mem_address];
        end
    endtask

    function automatic logic [31:0] encode_instruction(input logic [3:0] op,
            input logic [2:0] cond, input logic immf, input logic [3:0] d,
            input logic [3:0] s, input logic [11:0] addr);
        return {op, cond, immf, d, s, 4'h0, addr};
    endfunction

    function automatic logic [4:0] flags_of(input logic [31:0] value, input logic carry);
        logic [4:0] f;
        f = '0;
        f[cpu_pkg::FLAG_Z] = (value == 32'h0);
        f[cpu_pkg::FLAG_N] = value[31];
        f[cpu_pkg::FLAG_E] = !value[0];
        f[cpu_pkg::FLAG_P] = ^value;
        f[cpu_pkg::FLAG_C] = carry;
        return f;
    endfunction

    function automatic bit cond_holds(input logic [2:0] cond, input logic [4:0] f);
        case (cond)
            3'd0:    return 1'b1;
            3'd1:    return f[cpu_pkg::FLAG_P];
            3'd2:    return f[cpu_pkg::FLAG_E];
            3'd3:    return f[cpu_pkg::FLAG_C];
            3'd4:    return f[cpu_pkg::FLAG_N];
            3'd5:    return f[cpu_pkg::FLAG_Z];
            3'd6:    return !f[cpu_pkg::FLAG_C];
            default: return !f[cpu_pkg::FLAG_Z];
        endcase
    endfunction

    // Steps one bit at a time and keeps the last bit that leaves as carry
    function automatic logic [32:0] shift_model(input logic [31:0] value,
            input logic [31:0] ctrl, input bit rotate);
        logic [31:0] v;
        logic        c;
        int          n;
        v = value;
        c = 1'b0;
        n = int'(ctrl[4:0]);
        for (int i = 0; i < n; i++) begin
            if (ctrl[5]) begin
                c = v[0];
                v = {rotate ? v[0] : 1'b0, v[31:1]};
            end else begin
                c = v[31];
                v = {v[30:0], rotate ? v[31] : 1'b0};
            end
        end
        return {c, v};
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        $display("[ERROR] %0d ns %s: expected %h, got %h", $time, name, expected, actual);
        error_count++;
    endtask

    // Returns at the falling edge before the handshake edge
    task automatic wait_request(input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!(mem_valid === 1'b1 && mem_ready === 1'b1) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!(mem_valid === 1'b1 && mem_ready === 1'b1)) begin
            $display("Timeout: no %s handshake within %0d cycles at %0d ns",
                     what, WAIT_LIMIT, $time);
            error_count++;
            timed_out = 1'b1;
        end
    endtask

    task automatic build_program;
        logic [31:0] rnd;
        logic [3:0]  op;
        logic [11:0] addr;
        int          target;
        for (int a = 0; a < 4096; a++) begin
            mem[a] = {a[11:0], 8'h5A, ~a[11:0]};
        end
        for (int k = 0; k < DATA_WORDS; k++) begin
            mem[DATA_BASE + k] = (k % 8 == 0) ? 32'h0 : $urandom;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            rnd = $urandom % 9;
            op  = (rnd[3:0] == cpu_pkg::HLT) ? cpu_pkg::CMP : rnd[3:0];
            rnd = $urandom;
            if (op == cpu_pkg::LD || op == cpu_pkg::STR) begin
                target = DATA_BASE + int'(rnd[5:0]);
            end else if (op == cpu_pkg::BRA) begin
                target = i + 1 + int'(rnd[2:0] % 6);
                target = (target > PROG_LEN) ? PROG_LEN : target;
            end else begin
                target = int'(rnd[11:0]);
            end
            addr   = target[11:0];
            rnd    = $urandom;
            mem[i] = encode_instruction(op, rnd[2:0], rnd[3], rnd[7:4], rnd[11:8], addr);
        end
        // Dump every register, then stop
        for (int r = 0; r < 16; r++) begin
            target = RESULT_BASE + r;
            mem[PROG_LEN + r] = encode_instruction(cpu_pkg::STR, 3'd0, 1'b0, r[3:0],
                                                   4'h0, target[11:0]);
        end
        mem[PROG_LEN + 16] = encode_instruction(cpu_pkg::HLT, 3'd0, 1'b0, 4'h0, 4'h0, 12'h0);
        for (int a = 0; a < 4096; a++) begin
            ref_mem[a] = mem[a];
        end
    endtask

    task automatic run_instruction(output bit stop);
        logic [31:0] instr;
        logic [3:0]  op;
        logic [3:0]  d;
        logic [11:0] addr;
        logic [31:0] srcv;
        logic [31:0] sum;
        logic [32:0] wide;
        logic [11:0] next_pc;
        stop = 1'b0;
        wait_request("fetch");
        if (timed_out) begin
            stop = 1'b1;
        end else begin
            if (mem_address !== pc_m) report_mismatch("fetch mem_address", 32'(pc_m),
                                                      32'(mem_address));
            if (mem_write !== 1'b0) report_mismatch("fetch mem_write", 32'h0, 32'(mem_write));
            instr   = ref_mem[pc_m];
            op      = instr[cpu_pkg::OPC_HI:cpu_pkg::OPC_LO];
            d       = instr[cpu_pkg::DST_HI:cpu_pkg::DST_LO];
            addr    = instr[cpu_pkg::ADR_HI:cpu_pkg::ADR_LO];
            srcv    = instr[cpu_pkg::IMM_FLAG_BIT] ? {20'h0, addr}
                                                   : regs_m[instr[cpu_pkg::SRC_HI:cpu_pkg::SRC_LO]];
            next_pc = pc_m + 12'd1;
            case (op)
                cpu_pkg::LD, cpu_pkg::STR: begin
                    wait_request("data");
                    if (!timed_out) begin
                        if (mem_address !== addr) report_mismatch("data mem_address",
                                                                  32'(addr), 32'(mem_address));
                        if (mem_write !== (op == cpu_pkg::STR)) report_mismatch("data mem_write",
                            32'(op == cpu_pkg::STR), 32'(mem_write));
                        if (op == cpu_pkg::LD) begin
                            regs_m[d] = ref_mem[addr];
                            flags_m   = flags_of(regs_m[d], 1'b0);
                        end else begin
                            if (mem_wdata !== regs_m[d]) report_mismatch("mem_wdata",
                                                                         regs_m[d], mem_wdata);
                            mem[mem_address] = mem_wdata;
                            ref_mem[addr]    = regs_m[d];
                            flags_m          = '0;
                        end
                    end
                end
                cpu_pkg::BRA: begin
                    if (cond_holds(instr[cpu_pkg::COND_HI:cpu_pkg::COND_LO], flags_m)) begin
                        next_pc = addr;
                    end
                end
                cpu_pkg::XOR: begin
                    regs_m[d] = regs_m[d] ^ srcv;
                    flags_m   = flags_of(regs_m[d], 1'b0);
                end
                cpu_pkg::ADD: begin
                    sum       = regs_m[d] + srcv;
                    // Unsigned wrap around means a carry out
                    flags_m   = flags_of(sum, sum < regs_m[d]);
                    regs_m[d] = sum;
                end
                cpu_pkg::ROT, cpu_pkg::SHF: begin
                    wide      = shift_model(regs_m[d], srcv, op == cpu_pkg::ROT);
                    regs_m[d] = wide[31:0];
                    flags_m   = flags_of(wide[31:0], wide[32]);
                end
                cpu_pkg::CMP: begin
                    regs_m[d] = ~srcv;
                    flags_m   = flags_of(regs_m[d], 1'b0);
                end
                cpu_pkg::HLT: stop = 1'b1;
                default: ;
            endcase
            pc_m = next_pc;
            stop = stop || timed_out;
        end
    endtask

    initial begin
        bit stop;
        int cycles;
        void'($urandom(32'h3764));
        mem_ready   = 1'b0;
        mem_rdata   = 32'h0;
        error_count = 0;
        instr_count = 0;
        timed_out   = 1'b0;
        build_program();
        for (int r = 0; r < 16; r++) begin
            regs_m[r] = 32'h0;
        end
        flags_m = '0;
        pc_m    = '0;

        // Memory responder draws its numbers from this seeded process
        fork
            serve_memory();
        join_none

        cycles = 0;
        @(negedge clk);
        while (reset !== 1'b0 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (reset !== 1'b0) begin
            $display("Timeout: reset was never released");
            error_count++;
            timed_out = 1'b1;
        end else if (mem_valid !== 1'b0 || mem_write !== 1'b0 || halted !== 1'b0) begin
            $display("Request or halted not idle after reset at %0d ns", $time);
            error_count++;
        end

        stop = timed_out;
        while (!stop) begin
            run_instruction(stop);
            instr_count++;
        end

        if (!timed_out) begin
            cycles = 0;
            while (halted !== 1'b1 && cycles < WAIT_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (halted !== 1'b1) begin
                $display("Timeout: halted did not rise after HLT");
                error_count++;
            end else begin
                // Quiet window after halting
                repeat (40) begin
                    @(negedge clk);
                    if (mem_valid !== 1'b0 || halted !== 1'b1) begin
                        $display("Core left the halted state or requested memory at %0d ns",
                                 $time);
                        error_count++;
                    end
                end
            end
        end

        $display("Run finished: %0d instructions, %0d check errors, %0d assertion failures",
                 instr_count, error_count, uut.u_assert.failures);
        if (error_count == 0 && uut.u_assert.failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
hdl/cpu_pkg.sv
hdl/exec_if.sv
hdl/cpu_control.sv
hdl/register_file.sv
hdl/arith_logic_unit.sv
hdl/shift_rotate_unit.sv
hdl/result_merge.sv
hdl/cpu_top.sv
testbench/clock_gen.sv
testbench/cpu_assert.sv
testbench/cpu_tb.sv
